//--- hw/sram_timing_pkg.sv
// Chip timing for a 55 ns asynchronous SRAM at a 16 ns system clock
// Counts round up, so a faster clock needs only CLOCK_NS changed
package sram_timing_pkg;

    // System clock period
    localparam int CLOCK_NS = 16;

    // Round a time in ns up to whole clock cycles
    function automatic int ns_to_cycles(input int ns);
        return (ns + CLOCK_NS - 1) / CLOCK_NS;
    endfunction

    // Output enable held until read data is valid (tAA)
    localparam int READ_CYCLES  = ns_to_cycles(55);
    // Minimum write enable pulse width (tWP)
    localparam int WRITE_CYCLES = ns_to_cycles(45);
    // Accept to bank ack, shared by reads and writes
    localparam int ACK_CYCLES   = READ_CYCLES + 1;

    // Counter wide enough to reach ACK_CYCLES
    localparam int CNT_WIDTH = $clog2(ACK_CYCLES + 1);

    // One-hot controller states
    localparam logic [4:0] ST_IDLE     = 5'b00001;
    localparam logic [4:0] ST_READ     = 5'b00010;
    localparam logic [4:0] ST_WR_PULSE = 5'b00100;
    localparam logic [4:0] ST_WR_WAIT  = 5'b01000;
    localparam logic [4:0] ST_RECOVER  = 5'b10000;

endpackage

//--- hw/wb_bus_pkg.sv
// Bus widths and address layout; the bank number sits above the chip address
// NUM_BANKS must stay a power of two so every bank field value maps to a chip
package wb_bus_pkg;

    // Data word size on the bus and at the chips
    localparam int DATA_WIDTH = 8;

    // Number of SRAM chips and the width of the bank field
    localparam int NUM_BANKS = 4;
    localparam int BANK_BITS = $clog2(NUM_BANKS);

    // Word address of a single chip
    localparam int RAM_ADDR_WIDTH = 10;

    // Bus word address covers all banks
    localparam int WB_ADDR_WIDTH = BANK_BITS + RAM_ADDR_WIDTH;

    // Field view of a bus address
    typedef struct packed {
        logic [BANK_BITS-1:0]      bank;
        logic [RAM_ADDR_WIDTH-1:0] offset;
    } wb_addr_fields_t;

    // Same word seen as raw bus address or as bank/offset fields
    typedef union packed {
        logic [WB_ADDR_WIDTH-1:0] raw;
        wb_addr_fields_t          fields;
    } wb_addr_u;

endpackage

//--- hw/bank_decoder.sv
// Stall is combinational from the address; the master must hold its request
// while it is high. Requests with wb_cycle_i low never reach a bank
module bank_decoder
    import wb_bus_pkg::*;
(
    input  logic [WB_ADDR_WIDTH-1:0]  wb_addr_i,
    input  logic                      wb_cycle_i,
    input  logic                      wb_strobe_i,
    input  logic [NUM_BANKS-1:0]      bank_stall_i,
    output logic [NUM_BANKS-1:0]      bank_req_o,
    output logic [RAM_ADDR_WIDTH-1:0] ram_offset_o,
    output logic                      wb_stall_o
);

    wb_addr_u             addr;
    logic [BANK_BITS-1:0] bank;
    logic                 bank_busy;
    logic                 req_valid;

    // Raw bus address in, fields out
    assign addr.raw     = wb_addr_i;
    assign bank         = addr.fields.bank;
    assign ram_offset_o = addr.fields.offset;

    // Busy flag of the bank this address points at
    assign bank_busy = bank_stall_i[bank];

    // Master sees only the addressed bank's stall
    // Other banks keep accepting while this one is busy
    assign wb_stall_o = bank_busy;

    // A live request needs cycle and strobe together
    assign req_valid = wb_cycle_i && wb_strobe_i && !bank_busy;

    // One-hot steer to the addressed bank
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_req_o[b] = req_valid && (bank == BANK_BITS'(b));
        end
    end

endmodule

//--- hw/sram_bank_ctrl.sv
// One transaction at a time; req_i is only looked at while idle and stall_o low
// Ack comes ACK_CYCLES after accept for reads and writes alike
module sram_bank_ctrl
    import wb_bus_pkg::*, sram_timing_pkg::*;
(
    input  logic                      wb_clock_i,
    input  logic                      rst_i,
    input  logic                      req_i,
    input  logic                      we_i,
    input  logic [RAM_ADDR_WIDTH-1:0] offset_i,
    input  logic [DATA_WIDTH-1:0]     data_i,
    output logic                      stall_o,
    output logic                      ack_o,
    output logic [DATA_WIDTH-1:0]     rd_data_o,
    output logic [RAM_ADDR_WIDTH-1:0] ram_addr_o,
    output logic [DATA_WIDTH-1:0]     ram_data_o,
    output logic                      ram_oe_o,
    output logic                      ram_we_o,
    output logic                      ram_data_oe_o,
    input  logic [DATA_WIDTH-1:0]     ram_data_i
);

    logic [4:0]           state;
    logic [CNT_WIDTH-1:0] cycle_count;

    // Control path: state, counter, strobes to the chip and the bus
    always_ff @(posedge wb_clock_i) begin
        if (rst_i) begin
            state         <= ST_IDLE;
            cycle_count   <= '0;
            stall_o       <= 1'b0;
            ack_o         <= 1'b0;
            ram_oe_o      <= 1'b0;
            ram_we_o      <= 1'b0;
            ram_data_oe_o <= 1'b0;
        end else begin
            // Counts edges since accept; cleared on accept
            cycle_count <= cycle_count + 1'b1;

            case (state)
                ST_IDLE: begin
                    if (req_i) begin
                        cycle_count   <= '0;
                        stall_o       <= 1'b1;
                        // Address and enable coincident, setup time is zero
                        ram_oe_o      <= !we_i;
                        ram_we_o      <= we_i;
                        ram_data_oe_o <= we_i;
                        state         <= we_i ? ST_WR_PULSE : ST_READ;
                    end
                end
                ST_READ: begin
                    // Data valid here, drop OE
                    if (cycle_count == CNT_WIDTH'(READ_CYCLES - 1)) begin
                        ram_oe_o <= 1'b0;
                    end
                    if (cycle_count == CNT_WIDTH'(ACK_CYCLES - 1)) begin
                        ack_o <= 1'b1;
                        state <= ST_RECOVER;
                    end
                end
                ST_WR_PULSE: begin
                    // End of WE pulse; chip latches data on release
                    if (cycle_count == CNT_WIDTH'(WRITE_CYCLES - 1)) begin
                        ram_we_o      <= 1'b0;
                        ram_data_oe_o <= 1'b0;
                        state         <= ST_WR_WAIT;
                    end
                end
                ST_WR_WAIT: begin
                    // Pad write out to the read latency
                    if (cycle_count == CNT_WIDTH'(ACK_CYCLES - 1)) begin
                        ack_o <= 1'b1;
                        state <= ST_RECOVER;
                    end
                end
                ST_RECOVER: begin
                    // Chip back to High-Z before next access
                    ack_o   <= 1'b0;
                    stall_o <= 1'b0;
                    state   <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Payload path, latched at accept and sampled at end of read access
    always_ff @(posedge wb_clock_i) begin
        if (state == ST_IDLE && req_i) begin
            ram_addr_o <= offset_i;
            ram_data_o <= data_i;
        end
        if (state == ST_READ && cycle_count == CNT_WIDTH'(READ_CYCLES - 1)) begin
            rd_data_o <= ram_data_i;
        end
    end

endmodule

//--- hw/bank_response_merge.sv
// Expects at most one bank ack per cycle, which the fixed bank latency gives
// Adds one cycle; wb_data_o holds the last captured word between acks
module bank_response_merge
    import wb_bus_pkg::*;
(
    input  logic                                 wb_clock_i,
    input  logic                                 rst_i,
    input  logic [NUM_BANKS-1:0]                 bank_ack_i,
    input  logic [NUM_BANKS-1:0][DATA_WIDTH-1:0] bank_data_i,
    output logic                                 wb_ack_o,
    output logic [DATA_WIDTH-1:0]                wb_data_o
);

    // Any bank done means one bus ack
    always_ff @(posedge wb_clock_i) begin
        if (rst_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= |bank_ack_i;
        end
    end

    // Capture from the acking bank only
    // Banks complete in accept order, so this keeps bus order too
    always_ff @(posedge wb_clock_i) begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (bank_ack_i[b]) begin
                wb_data_o <= bank_data_i[b];
            end
        end
    end

endmodule

//--- hw/banked_sram_top.sv
// Four SRAM chips behind one pipelined Wishbone slave, one transaction per bank
// Tristate control is ram_data_oe_o; pads are resolved outside this block
module banked_sram_top
    import wb_bus_pkg::*;
(
    // Wishbone B4 pipelined slave
    input  logic                                     wb_clock_i,
    input  logic                                     rst_i,
    input  logic [WB_ADDR_WIDTH-1:0]                 wb_addr_i,
    input  logic [DATA_WIDTH-1:0]                    wb_data_i,
    input  logic                                     wb_we_i,
    input  logic                                     wb_cycle_i,
    input  logic                                     wb_strobe_i,
    output logic [DATA_WIDTH-1:0]                    wb_data_o,
    output logic                                     wb_stall_o,
    output logic                                     wb_ack_o,

    // SRAM chip pins, indexed by bank
    output logic [NUM_BANKS-1:0][RAM_ADDR_WIDTH-1:0] ram_addr_o,
    output logic [NUM_BANKS-1:0][DATA_WIDTH-1:0]     ram_data_o,
    output logic [NUM_BANKS-1:0]                     ram_oe_o,
    output logic [NUM_BANKS-1:0]                     ram_we_o,
    output logic [NUM_BANKS-1:0]                     ram_data_oe_o,
    input  logic [NUM_BANKS-1:0][DATA_WIDTH-1:0]     ram_data_i
);

    logic [NUM_BANKS-1:0]                 bank_req;
    logic [NUM_BANKS-1:0]                 bank_stall;
    logic [NUM_BANKS-1:0]                 bank_ack;
    logic [NUM_BANKS-1:0][DATA_WIDTH-1:0] bank_rd_data;
    logic [RAM_ADDR_WIDTH-1:0]            ram_offset;

    // Address split and strobe steering
    bank_decoder u_decoder (
        .wb_addr_i    (wb_addr_i),
        .wb_cycle_i   (wb_cycle_i),
        .wb_strobe_i  (wb_strobe_i),
        .bank_stall_i (bank_stall),
        .bank_req_o   (bank_req),
        .ram_offset_o (ram_offset),
        .wb_stall_o   (wb_stall_o)
    );

    // One controller per chip; offset, data and we are shared
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        sram_bank_ctrl u_ctrl (
            .wb_clock_i    (wb_clock_i),
            .rst_i         (rst_i),
            .req_i         (bank_req[b]),
            .we_i          (wb_we_i),
            .offset_i      (ram_offset),
            .data_i        (wb_data_i),
            .stall_o       (bank_stall[b]),
            .ack_o         (bank_ack[b]),
            .rd_data_o     (bank_rd_data[b]),
            .ram_addr_o    (ram_addr_o[b]),
            .ram_data_o    (ram_data_o[b]),
            .ram_oe_o      (ram_oe_o[b]),
            .ram_we_o      (ram_we_o[b]),
            .ram_data_oe_o (ram_data_oe_o[b]),
            .ram_data_i    (ram_data_i[b])
        );
    end

    // Acks and read data back onto the bus
    bank_response_merge u_merge (
        .wb_clock_i  (wb_clock_i),
        .rst_i       (rst_i),
        .bank_ack_i  (bank_ack),
        .bank_data_i (bank_rd_data),
        .wb_ack_o    (wb_ack_o),
        .wb_data_o   (wb_data_o)
    );

endmodule

//--- test/sram_chip_model.sv
// Behavioral asynchronous SRAM with zero access time and no timing checks
// Unwritten words read a fill built from the full bus address, bank in the top bits
module sram_chip_model
    import wb_bus_pkg::*;
#(
    parameter int BANK_ID = 0
) (
    input  logic [RAM_ADDR_WIDTH-1:0] addr_i,
    input  logic [DATA_WIDTH-1:0]     data_i,
    input  logic                      oe_i,
    input  logic                      we_i,
    output logic [DATA_WIDTH-1:0]     data_o
);

    logic [DATA_WIDTH-1:0]    mem [1 << RAM_ADDR_WIDTH];
    logic [WB_ADDR_WIDTH-1:0] full_addr;

    // Power-up contents, low address byte mixed with bank and high offset bits
    initial begin
        for (int a = 0; a < (1 << RAM_ADDR_WIDTH); a++) begin
            full_addr = {BANK_BITS'(BANK_ID), RAM_ADDR_WIDTH'(a)};
            mem[a] = full_addr[7:0] ^ {full_addr[11:8], full_addr[11:8]};
        end
    end

    // Data pins driven only while output enable is high
    assign data_o = oe_i ? mem[addr_i] : '0;

    // Chip latches the data as write enable is released
    always @(negedge we_i) begin
        mem[addr_i] = data_i;
    end

endmodule

//--- test/tb_banked_sram.sv
// Self-checking bench driven by directed lines in test/stimulus_input.txt
// Shadow memory mirrors the power-up fill of the chip models
module tb_banked_sram;
    import wb_bus_pkg::*;

    // Polling limit for every wait in clock cycles
    localparam int TIMEOUT = 50;
    // Falling edges from accept to the bus ack
    localparam int BUS_LATENCY = 7;

    logic                                     wb_clock_i = 1'b0;
    logic                                     rst_i;
    logic [WB_ADDR_WIDTH-1:0]                 wb_addr_i;
    logic [DATA_WIDTH-1:0]                    wb_data_i;
    logic                                     wb_we_i;
    logic                                     wb_cycle_i;
    logic                                     wb_strobe_i;
    logic [DATA_WIDTH-1:0]                    wb_data_o;
    logic                                     wb_stall_o;
    logic                                     wb_ack_o;
    logic [NUM_BANKS-1:0][RAM_ADDR_WIDTH-1:0] ram_addr_o;
    logic [NUM_BANKS-1:0][DATA_WIDTH-1:0]     ram_data_o;
    logic [NUM_BANKS-1:0]                     ram_oe_o;
    logic [NUM_BANKS-1:0]                     ram_we_o;
    logic [NUM_BANKS-1:0]                     ram_data_oe_o;
    logic [NUM_BANKS-1:0][DATA_WIDTH-1:0]     ram_data_i;

    logic [DATA_WIDTH-1:0] shadow [1 << WB_ADDR_WIDTH];
    logic [DATA_WIDTH-1:0] ack_data_q [$];
    logic [31:0]           stim [32];
    logic [31:0]           rand_state = 32'ha119;

    always #4 wb_clock_i = ~wb_clock_i;

    banked_sram_top UUT (.*);

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_chip
        sram_chip_model #(.BANK_ID(b)) u_chip (
            .addr_i (ram_addr_o[b]),
            .data_i (ram_data_o[b]),
            .oe_i   (ram_oe_o[b]),
            .we_i   (ram_we_o[b]),
            .data_o (ram_data_i[b])
        );
    end

    // One queue entry per bus ack in arrival order
    // Chip data pins are driven exactly while write enable is high
    always @(posedge wb_clock_i) begin
        if (!rst_i && wb_ack_o) begin
            ack_data_q.push_back(wb_data_o);
        end
        if (!rst_i) begin
            assert (ram_data_oe_o == ram_we_o) else begin
                $display("[FAIL] ram_data_oe_o: got %h expected %h", ram_data_oe_o, ram_we_o);
                abort_run();
            end
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Same power-up fill as the chip models
    function automatic logic [7:0] fill_byte(input logic [WB_ADDR_WIDTH-1:0] a);
        return a[7:0] ^ {a[11:8], a[11:8]};
    endfunction

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] expected);
        assert (got == expected) else begin
            $display("[FAIL] %s: got %h expected %h", name, got, expected);
            abort_run();
        end
    endtask

    // Idle levels on the bus and every chip strobe
    task automatic check_quiet();
        assert (!wb_ack_o && !wb_stall_o) else begin
            $display("[FAIL] wb_ack_o/wb_stall_o: got %h/%h expected 0/0", wb_ack_o, wb_stall_o);
            abort_run();
        end
        assert (ram_oe_o == '0 && ram_we_o == '0 && ram_data_oe_o == '0) else begin
            $display("[FAIL] ram_oe_o/ram_we_o/ram_data_oe_o: got %h/%h/%h expected 0/0/0",
                     ram_oe_o, ram_we_o, ram_data_oe_o);
            abort_run();
        end
    endtask

    // Starts on a falling edge and returns on the falling edge after accept
    task automatic issue(input logic we, input logic [WB_ADDR_WIDTH-1:0] addr,
                         input logic [DATA_WIDTH-1:0] data, output int stalls);
        wb_cycle_i  = 1'b1;
        wb_strobe_i = 1'b1;
        wb_we_i     = we;
        wb_addr_i   = addr;
        wb_data_i   = data;
        stalls      = 0;
        #1;
        while (wb_stall_o) begin
            @(negedge wb_clock_i);
            #1;
            stalls++;
            if (stalls > TIMEOUT) begin
                $display("Timed out: bank %0d never dropped its stall", addr[11:10]);
                abort_run();
            end
        end
        if (we) begin
            shadow[addr] = data;
        end
        @(negedge wb_clock_i);
    endtask

    task automatic go_idle();
        wb_cycle_i  = 1'b0;
        wb_strobe_i = 1'b0;
    endtask

    // Count starts at 1 for the falling edge right after accept
    task automatic wait_ack_high(output int cycles);
        cycles = 1;
        while (!wb_ack_o) begin
            @(negedge wb_clock_i);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timed out: wb_ack_o never rose");
                abort_run();
            end
        end
    endtask

    task automatic wait_acks(input int n);
        int waited;
        waited = 0;
        while (ack_data_q.size() < n) begin
            @(negedge wb_clock_i);
            waited++;
            if (waited > TIMEOUT) begin
                $display("Timed out: only %0d of %0d acks arrived", ack_data_q.size(), n);
                abort_run();
            end
        end
    endtask

    // Single transaction on an idle bank with reads checked against the shadow
    task automatic run_op(input logic we, input logic [WB_ADDR_WIDTH-1:0] addr,
                          input logic [DATA_WIDTH-1:0] data, input bit timed,
                          output logic [DATA_WIDTH-1:0] got);
        int stalls;
        int cycles;
        issue(we, addr, data, stalls);
        assert (stalls == 0) else begin
            $display("[FAIL] wb_stall_o: got %h expected %h", 1'b1, 1'b0);
            abort_run();
        end
        go_idle();
        if (timed) begin
            wait_ack_high(cycles);
            assert (cycles == BUS_LATENCY) else begin
                $display("[FAIL] wb_ack_o latency: got %h expected %h", cycles, BUS_LATENCY);
                abort_run();
            end
            @(negedge wb_clock_i);
            assert (!wb_ack_o) else begin
                $display("[FAIL] wb_ack_o width: got %h expected %h", wb_ack_o, 1'b0);
                abort_run();
            end
        end
        wait_acks(1);
        got = ack_data_q.pop_front();
        if (!we) begin
            check_byte("wb_data_o", got, shadow[addr]);
        end
    endtask

    initial begin
        logic [DATA_WIDTH-1:0] got;
        int                    stalls;
        int                    cycles;

        rst_i       = 1'b1;
        wb_addr_i   = '0;
        wb_data_i   = '0;
        wb_we_i     = 1'b0;
        wb_cycle_i  = 1'b0;
        wb_strobe_i = 1'b0;
        for (int i = 0; i < (1 << WB_ADDR_WIDTH); i++) begin
            shadow[i] = fill_byte(WB_ADDR_WIDTH'(i));
        end
        // Op nibble F marks the end of the directed list
        for (int i = 0; i < 32; i++) begin
            stim[i] = 32'hFFFF_FFFF;
        end
        $readmemh("test/stimulus_input.txt", stim);

        // Outputs stay quiet through the 4 reset cycles and the one after
        repeat (4) begin
            @(negedge wb_clock_i);
            check_quiet();
        end
        rst_i = 1'b0;
        @(negedge wb_clock_i);
        check_quiet();

        // Directed list from the data file
        for (int i = 0; i < 32 && stim[i][31:28] != 4'hF; i++) begin
            run_op(stim[i][28], stim[i][27:16], stim[i][15:8], 1'b0, got);
            if (!stim[i][28]) begin
                check_byte("wb_data_o", got, stim[i][7:0]);
            end
        end

        // Exact ack position and width for an isolated write and read
        run_op(1'b1, 12'h9A5, 8'h3C, 1'b1, got);
        run_op(1'b0, 12'h9A5, 8'h00, 1'b1, got);

        // One write per bank on back-to-back cycles
        for (int b = 0; b < NUM_BANKS; b++) begin
            issue(1'b1, {2'(b), 10'h155}, 8'hC0 + 8'(b), stalls);
            assert (stalls == 0) else begin
                $display("[FAIL] wb_stall_o: got %h expected %h", 1'b1, 1'b0);
                abort_run();
            end
        end
        go_idle();
        wait_ack_high(cycles);
        // First ack counted from the last accept, three cycles after the first one
        assert (cycles == BUS_LATENCY - (NUM_BANKS - 1)) else begin
            $display("[FAIL] wb_ack_o latency: got %h expected %h",
                     cycles, BUS_LATENCY - (NUM_BANKS - 1));
            abort_run();
        end
        repeat (NUM_BANKS - 1) begin
            @(negedge wb_clock_i);
            assert (wb_ack_o) else begin
                $display("[FAIL] wb_ack_o: got %h expected %h", wb_ack_o, 1'b1);
                abort_run();
            end
        end
        wait_acks(NUM_BANKS);
        ack_data_q.delete();
        // Reads in bank order return the data in issue order
        for (int b = 0; b < NUM_BANKS; b++) begin
            issue(1'b0, {2'(b), 10'h155}, 8'h00, stalls);
        end
        go_idle();
        wait_acks(NUM_BANKS);
        for (int b = 0; b < NUM_BANKS; b++) begin
            check_byte("wb_data_o", ack_data_q.pop_front(), shadow[{2'(b), 10'h155}]);
        end

        // Second request to the same bank waits out the stall
        issue(1'b1, 12'h2AA, 8'h5E, stalls);
        issue(1'b0, 12'h2AA, 8'h00, stalls);
        assert (stalls > 0) else begin
            $display("[FAIL] wb_stall_o: got %h expected %h", 1'b0, 1'b1);
            abort_run();
        end
        go_idle();
        wait_acks(2);
        void'(ack_data_q.pop_front());
        check_byte("wb_data_o", ack_data_q.pop_front(), 8'h5E);

        // Random traffic over a small window per bank so reads hit earlier writes
        repeat (200) begin
            rand_state = lcg_next(rand_state);
            run_op(rand_state[24], {rand_state[31:30], 7'd0, rand_state[18:16]},
                   rand_state[15:8], 1'b0, got);
        end

        // Strobe without a cycle must stay unanswered
        wb_cycle_i  = 1'b0;
        wb_strobe_i = 1'b1;
        wb_addr_i   = 12'h123;
        repeat (TIMEOUT) begin
            @(negedge wb_clock_i);
            assert (!wb_ack_o && ack_data_q.size() == 0) else begin
                $display("[FAIL] wb_ack_o: got %h expected %h", wb_ack_o, 1'b0);
                abort_run();
            end
        end
        wb_strobe_i = 1'b0;

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- test/stimulus_input.txt
// One 32-bit word per transaction: op_addr_data_expect
// op 1 = write, 0 = read; addr holds bank (2 bits) and offset (10); expect is for reads
1_000_11_00
1_3FF_22_00
1_400_33_00
1_7FF_44_00
1_800_55_00
1_BFF_66_00
1_C00_FF_00
1_FFF_88_00
0_000_00_11
0_3FF_00_22
0_400_00_33
0_7FF_00_44
0_800_00_55
0_BFF_00_66
0_C00_00_FF
0_FFF_00_88
1_3FF_A5_00
0_3FF_00_A5

//--- filelist.f
hw/sram_timing_pkg.sv
hw/wb_bus_pkg.sv
hw/bank_decoder.sv
hw/sram_bank_ctrl.sv
hw/bank_response_merge.sv
hw/banked_sram_top.sv
test/sram_chip_model.sv
test/tb_banked_sram.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the banked SRAM testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -f filelist.f --top-module tb_banked_sram \
    -Mdir "$BUILD_DIR" -o sim_banked_sram
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_banked_sram" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG_FILE"; then
    exit 0
else
    echo "Pass message not found in $LOG_FILE"
    exit 1
fi
